//--- design/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	typedef logic [7:0]  reg_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t; // Byte n in bits 8n+7:8n.
	typedef logic [6:0]  dev_addr_t;
	typedef logic [1:0]  nby_t;  // Byte count minus one.

	localparam reg_addr_t REG_NBY  = 8'h00;
	localparam reg_addr_t REG_ADR  = 8'h04;
	localparam reg_addr_t REG_RDR0 = 8'h08;
	localparam reg_addr_t REG_TDR0 = 8'h0C;
	localparam reg_addr_t REG_CTRL = 8'h10;

	// CTRL bits, write side.
	localparam int CTRL_GO   = 0;
	localparam int CTRL_READ = 1;
	// CTRL bits, read side.
	localparam int CTRL_BUSY = 0;
	localparam int CTRL_DONE = 1;
	localparam int CTRL_NACK = 2;

	typedef struct packed {
		logic      sel;
		logic      enable;
		logic      write;
		reg_addr_t addr;
		byte_t     wdata;
	} apb_req_t;

	typedef struct packed {
		logic      read;
		dev_addr_t addr;
		nby_t      nby;
		word_t     tdr;
	} i2c_cmd_t;

	typedef enum logic [2:0] {
		ST_IDLE, ST_START, ST_ADDR, ST_ACK0, ST_WDATA, ST_RDATA, ST_ACK1, ST_STOP
	} eng_state_t;

endpackage

`default_nettype wire

//--- design/i2c_regs.sv
`default_nettype none

module i2c_regs (
	input  logic               clk_i,
	input  logic               rst,
	input  i2c_pkg::apb_req_t  req_i,
	output i2c_pkg::byte_t     rdata_o,
	output logic               ready_o,
	output logic               cmd_valid_o,
	output i2c_pkg::i2c_cmd_t  cmd_o,
	input  logic               rx_we_i,
	input  i2c_pkg::nby_t      rx_idx_i,
	input  i2c_pkg::byte_t     rx_byte_i,
	input  logic               done_i,
	input  logic               nack_i
);
	import i2c_pkg::*;

	logic      setup;
	logic      wr_setup;
	logic      rd_setup;
	logic      go;
	logic [4:0] lane;
	byte_t     rd_val;
	nby_t      nby;
	dev_addr_t adr;
	word_t     tdr;
	word_t     rdr;
	logic      rd_dir;
	logic      busy;
	logic      done;
	logic      nack;

	assign setup    = req_i.sel && !req_i.enable;
	assign wr_setup = setup && req_i.write;
	assign rd_setup = setup && !req_i.write;
	assign lane     = {req_i.addr[1:0], 3'b000}; // Bit offset of the byte lane.

	// Only an idle controller takes a go.
	assign go = wr_setup && (req_i.addr == REG_CTRL) && req_i.wdata[CTRL_GO] && !busy;

	always_comb begin
		rd_val = '0;
		if (req_i.addr == REG_NBY)
			rd_val[1:0] = nby;
		else if (req_i.addr == REG_ADR)
			rd_val[6:0] = adr;
		else if (req_i.addr[7:2] == REG_RDR0[7:2])
			rd_val = rdr[lane +: 8];
		else if (req_i.addr[7:2] == REG_TDR0[7:2])
			rd_val = tdr[lane +: 8];
		else if (req_i.addr == REG_CTRL) begin
			rd_val[CTRL_BUSY] = busy;
			rd_val[CTRL_DONE] = done;
			rd_val[CTRL_NACK] = nack;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst) begin
			ready_o <= 1'b1;
			rdata_o <= '0;
		end else begin
			ready_o <= req_i.sel ? req_i.enable : 1'b1; // Low one cycle after setup.
			if (rd_setup)
				rdata_o <= rd_val;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst) begin
			nby <= '0;
			adr <= '0;
			tdr <= '0;
		end else if (wr_setup) begin
			if (req_i.addr == REG_NBY)
				nby <= req_i.wdata[1:0];
			else if (req_i.addr == REG_ADR)
				adr <= req_i.wdata[6:0];
			else if (req_i.addr[7:2] == REG_TDR0[7:2])
				tdr[lane +: 8] <= req_i.wdata;
		end
	end

	// Received bytes from the engine.
	always_ff @(posedge clk_i) begin
		if (rst)
			rdr <= '0;
		else if (rx_we_i)
			rdr[{rx_idx_i, 3'b000} +: 8] <= rx_byte_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst) begin
			cmd_valid_o <= 1'b0;
			rd_dir      <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
			nack        <= 1'b0;
		end else begin
			cmd_valid_o <= go;
			if (go) begin
				rd_dir <= req_i.wdata[CTRL_READ];
				busy   <= 1'b1;
				done   <= 1'b0;
				nack   <= 1'b0;
			end else if (done_i) begin
				busy <= 1'b0;
				done <= 1'b1;
				nack <= nack_i; // Sticky until the next go.
			end
		end
	end

	assign cmd_o = '{read: rd_dir, addr: adr, nby: nby, tdr: tdr};

endmodule

`default_nettype wire

//--- design/i2c_scl_gen.sv
`default_nettype none

module i2c_scl_gen #(
	parameter int CLK_DIV = 4
) (
	input  logic       clk_i,
	input  logic       rst,
	input  logic       run_i,
	output logic       tick_o,
	output logic [1:0] phase_o,
	output logic       scl_o
);

	localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [CW-1:0] cnt;
	logic [1:0]    phase;

	// Last cycle of the current quarter bit.
	assign tick_o = run_i && (cnt == CW'(CLK_DIV - 1));

	always_ff @(posedge clk_i) begin
		if (rst || !run_i) begin
			cnt   <= '0;
			phase <= '0;
		end else if (tick_o) begin
			cnt   <= '0;
			phase <= phase + 2'd1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign phase_o = phase;

	// Low in phases 0 and 1, released when idle.
	assign scl_o = !run_i || phase[1];

endmodule

`default_nettype wire

//--- design/i2c_engine.sv
`default_nettype none

module i2c_engine (
	input  logic              clk_i,
	input  logic              rst,
	input  logic              cmd_valid_i,
	input  i2c_pkg::i2c_cmd_t cmd_i,
	input  logic              tick_i,
	input  logic [1:0]        phase_i,
	input  logic              sda_i,
	output logic              run_o,
	output logic              sda_o,
	output logic              rx_we_o,
	output i2c_pkg::nby_t     rx_idx_o,
	output i2c_pkg::byte_t    rx_byte_o,
	output logic              done_o,
	output logic              nack_o
);
	import i2c_pkg::*;

	eng_state_t state;
	i2c_cmd_t   cmd_q;
	logic [2:0] bit_cnt;
	nby_t       byte_cnt;
	nby_t       byte_nxt;
	byte_t      shift;
	logic       ack_q;
	logic       drive_bit;
	logic       last_byte;

	assign byte_nxt  = byte_cnt + 2'd1;
	assign last_byte = (byte_cnt == cmd_q.nby);

	// SDA level for the data part of the bit, set in phase 0.
	always_comb begin
		unique case (state)
			ST_ADDR, ST_WDATA: drive_bit = shift[7];
			ST_ACK1:           drive_bit = cmd_q.read ? last_byte : 1'b1; // NACK on last.
			ST_STOP:           drive_bit = 1'b0;
			default:           drive_bit = 1'b1;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst) begin
			state    <= ST_IDLE;
			run_o    <= 1'b0;
			sda_o    <= 1'b1;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			rx_we_o  <= 1'b0;
			done_o   <= 1'b0;
			nack_o   <= 1'b0;
		end else begin
			rx_we_o <= 1'b0;
			done_o  <= 1'b0;

			if (state == ST_IDLE && cmd_valid_i) begin
				cmd_q  <= cmd_i;
				nack_o <= 1'b0;
				run_o  <= 1'b1;
				state  <= ST_START;
			end

			if (tick_i && phase_i == 2'd0)
				sda_o <= drive_bit;

			// SCL high. START and STOP edges, sampling.
			if (tick_i && phase_i == 2'd2) begin
				unique case (state)
					ST_START:         sda_o <= 1'b0;
					ST_STOP:          sda_o <= 1'b1;
					ST_ACK0, ST_ACK1: ack_q <= sda_i;
					ST_RDATA:         shift <= {shift[6:0], sda_i};
					default:          ;
				endcase
			end

			// End of bit.
			if (tick_i && phase_i == 2'd3) begin
				unique case (state)
					ST_START: begin
						shift   <= {cmd_q.addr, cmd_q.read};
						bit_cnt <= 3'd7;
						state   <= ST_ADDR;
					end
					ST_ADDR, ST_WDATA: begin
						shift <= {shift[6:0], 1'b0};
						if (bit_cnt == 3'd0)
							state <= (state == ST_ADDR) ? ST_ACK0 : ST_ACK1;
						else
							bit_cnt <= bit_cnt - 3'd1;
					end
					ST_ACK0: begin
						if (ack_q) begin
							nack_o <= 1'b1;
							state  <= ST_STOP;
						end else begin
							byte_cnt <= '0;
							bit_cnt  <= 3'd7;
							if (cmd_q.read) begin
								state <= ST_RDATA;
							end else begin
								shift <= cmd_q.tdr[7:0];
								state <= ST_WDATA;
							end
						end
					end
					ST_RDATA: begin
						if (bit_cnt == 3'd0) begin
							rx_we_o <= 1'b1;
							state   <= ST_ACK1;
						end else begin
							bit_cnt <= bit_cnt - 3'd1;
						end
					end
					ST_ACK1: begin
						if (!cmd_q.read && ack_q) begin
							nack_o <= 1'b1;
							state  <= ST_STOP;
						end else if (last_byte) begin
							state <= ST_STOP;
						end else begin
							byte_cnt <= byte_nxt;
							bit_cnt  <= 3'd7;
							if (cmd_q.read) begin
								state <= ST_RDATA;
							end else begin
								shift <= cmd_q.tdr[{byte_nxt, 3'b000} +: 8];
								state <= ST_WDATA;
							end
						end
					end
					ST_STOP: begin
						run_o  <= 1'b0;
						done_o <= 1'b1;
						state  <= ST_IDLE;
					end
					default: ;
				endcase
			end
		end
	end

	assign rx_idx_o  = byte_cnt;
	assign rx_byte_o = shift; // Stable from phase 2 until the next byte.

endmodule

`default_nettype wire

//--- design/i2c_master.sv
`default_nettype none

module i2c_master #(
	parameter int CLK_DIV = 4
) (
	input  logic              clk_i,
	input  logic              rst,
	input  i2c_pkg::apb_req_t req_i,
	output i2c_pkg::byte_t    rdata_o,
	output logic              ready_o,
	input  logic              sda_i,
	output logic              sda_o,
	output logic              scl_o
);
	import i2c_pkg::*;

	logic       cmd_valid;
	i2c_cmd_t   cmd;
	logic       rx_we;
	nby_t       rx_idx;
	byte_t      rx_byte;
	logic       done;
	logic       nack;
	logic       run;
	logic       tick;
	logic [1:0] phase;

	i2c_regs u_regs (
		.clk_i       (clk_i),
		.rst         (rst),
		.req_i       (req_i),
		.rdata_o     (rdata_o),
		.ready_o     (ready_o),
		.cmd_valid_o (cmd_valid),
		.cmd_o       (cmd),
		.rx_we_i     (rx_we),
		.rx_idx_i    (rx_idx),
		.rx_byte_i   (rx_byte),
		.done_i      (done),
		.nack_i      (nack)
	);

	i2c_scl_gen #(
		.CLK_DIV (CLK_DIV)
	) u_scl (
		.clk_i   (clk_i),
		.rst     (rst),
		.run_i   (run),
		.tick_o  (tick),
		.phase_o (phase),
		.scl_o   (scl_o)
	);

	i2c_engine u_engine (
		.clk_i       (clk_i),
		.rst         (rst),
		.cmd_valid_i (cmd_valid),
		.cmd_i       (cmd),
		.tick_i      (tick),
		.phase_i     (phase),
		.sda_i       (sda_i),
		.run_o       (run),
		.sda_o       (sda_o),
		.rx_we_o     (rx_we),
		.rx_idx_o    (rx_idx),
		.rx_byte_o   (rx_byte),
		.done_o      (done),
		.nack_o      (nack)
	);

endmodule

`default_nettype wire

//--- sim/i2c_target_model.sv
`default_nettype none

module i2c_target_model (
	input  logic               clk_i,
	input  logic               rst,
	input  logic               scl_i,
	input  logic               sda_i,
	input  i2c_pkg::dev_addr_t dev_addr_i,
	input  i2c_pkg::word_t     served_i,
	output logic               sda_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import i2c_pkg::*;

	byte_t frame[$]; // Bytes written by the master, address first.
	logic  acks[$];  // Master ACK bits in reads.
	int    stops;
	logic  scl_q;
	logic  sda_q;
	logic  active;
	logic  sel;
	logic  rd;
	logic  ack_done;
	int    bit_idx;
	int    byte_no;
	byte_t sh;
	byte_t tx;

	task automatic clear();
		frame.delete();
		acks.delete();
		stops = 0;
	endtask

	always @(posedge clk_i) begin
		scl_q <= scl_i;
		sda_q <= sda_i;
		if (rst) begin
			sda_o <= 1'b1;
			active = 1'b0;
			stops = 0;
		end else if (scl_i && scl_q && sda_q && !sda_i) begin
			active = 1'b1; // START.
			bit_idx = 0;
			byte_no = 0;
			ack_done = 1'b0;
			sel = 1'b0;
			rd = 1'b0;
		end else if (scl_i && scl_q && !sda_q && sda_i) begin
			if (active)
				stops++;
			active = 1'b0;
			sda_o <= 1'b1;
		end else if (active && scl_i && !scl_q) begin
			if (bit_idx == 8) begin
				if (sel && rd && byte_no > 0)
					acks.push_back(sda_i);
				ack_done = 1'b1;
			end else begin
				sh = {sh[6:0], sda_i};
				bit_idx++;
			end
		end else if (active && !scl_i && scl_q) begin
			if (ack_done) begin
				bit_idx = 0;
				ack_done = 1'b0;
				byte_no++;
				if (sel && rd && (byte_no == 1 || acks[$] == 1'b0)) begin
					tx = served_i[8*((byte_no-1)%4) +: 8];
					sda_o <= tx[7];
				end else begin
					sda_o <= 1'b1;
				end
			end else if (bit_idx == 8) begin
				if (byte_no == 0) begin
					frame.push_back(sh);
					sel = (sh[7:1] == dev_addr_i);
					rd = sh[0];
					sda_o <= !sel; // ACK only our own address.
				end else if (sel && !rd) begin
					frame.push_back(sh);
					sda_o <= 1'b0;
				end else begin
					sda_o <= 1'b1;
				end
			end else if (bit_idx > 0 && sel && rd && byte_no > 0) begin
				sda_o <= tx[7-bit_idx];
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/i2c_master_asserts.sv
`default_nettype none

module i2c_master_asserts (
	input logic                clk_i,
	input logic                rst,
	input i2c_pkg::apb_req_t   req_i,
	input logic                ready_o,
	input logic                sda_o,
	input logic                scl_o,
	input logic                cmd_valid,
	input logic                busy,
	input i2c_pkg::eng_state_t state
);
	timeunit 1ns;
	timeprecision 100ps;
	import i2c_pkg::*;

	ready_after_setup: assert property (@(posedge clk_i) disable iff (rst)
		(req_i.sel && !req_i.enable) |=> !ready_o)
		else $error("ready_o high in the cycle after a setup phase");

	// Only START and STOP move SDA under a high SCL.
	sda_stable_scl_high: assert property (@(posedge clk_i) disable iff (rst)
		(scl_o && $past(scl_o) && (sda_o != $past(sda_o)))
		|-> (state == ST_START || state == ST_STOP))
		else $error("SDA changed while SCL high outside START or STOP");

	// A command only reaches an idle engine.
	no_go_while_busy: assert property (@(posedge clk_i) disable iff (rst)
		cmd_valid |-> (state == ST_IDLE))
		else $error("cmd_valid issued while the engine was running");

	busy_covers_engine: assert property (@(posedge clk_i) disable iff (rst)
		(state != ST_IDLE) |-> busy)
		else $error("engine running while CTRL busy was clear");

endmodule

bind i2c_master i2c_master_asserts u_asserts (
	.clk_i     (clk_i),
	.rst       (rst),
	.req_i     (req_i),
	.ready_o   (ready_o),
	.sda_o     (sda_o),
	.scl_o     (scl_o),
	.cmd_valid (cmd_valid),
	.busy      (u_regs.busy),
	.state     (u_engine.state)
);

`default_nettype wire

//--- sim/tb_i2c_master.sv
`default_nettype none

module tb_i2c_master;
	timeunit 1ns;
	timeprecision 100ps;
	import i2c_pkg::*;

	localparam int        CLK_DIV = 3;
	localparam dev_addr_t DEV     = 7'h3a;

	logic        clk_i = 1'b0;
	logic        rst;
	apb_req_t    req;
	byte_t       rdata;
	logic        ready;
	logic        sda_o;
	logic        scl;
	logic        tgt_sda;
	logic        sda_bus;
	dev_addr_t   tgt_addr;
	word_t       served;
	word_t       rdr_model;
	logic [31:0] lcg_state;

	always #2 clk_i = ~clk_i;

	assign sda_bus = sda_o & tgt_sda; // Open-drain wired-AND.

	i2c_master #(.CLK_DIV(CLK_DIV)) i_dut (
		.clk_i   (clk_i),
		.rst     (rst),
		.req_i   (req),
		.rdata_o (rdata),
		.ready_o (ready),
		.sda_i   (sda_bus),
		.sda_o   (sda_o),
		.scl_o   (scl)
	);

	i2c_target_model u_target (
		.clk_i      (clk_i),
		.rst        (rst),
		.scl_i      (scl),
		.sda_i      (sda_bus),
		.dev_addr_i (tgt_addr),
		.served_i   (served),
		.sda_o      (tgt_sda)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Bytes the target should see written, address byte first.
	function automatic int expect_frame(input dev_addr_t a, input logic rd, input nby_t n,
			input word_t tdr, output byte_t fr[5]);
		int cnt;
		cnt = 1;
		fr[0] = {a, rd};
		for (int i = 1; i < 5; i++)
			fr[i] = '0;
		if (!rd) begin
			for (int i = 0; i <= int'(n); i++) begin
				fr[cnt] = tdr[8*i +: 8];
				cnt++;
			end
		end
		return cnt;
	endfunction

	task automatic fail_value(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
			fail_value($sformatf("%s: got %02h, expected %02h", what, got, exp));
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			fail_value($sformatf("%s: got %08h, expected %08h", what, got, exp));
	endtask

	task automatic check_status(input byte_t ctrl, input logic busy, input logic done,
			input logic nack);
		byte_t exp;
		exp = '0;
		exp[CTRL_BUSY] = busy;
		exp[CTRL_DONE] = done;
		exp[CTRL_NACK] = nack;
		if (ctrl !== exp)
			fail_value($sformatf("CTRL status: got %02h, expected %02h", ctrl, exp));
	endtask

	task automatic bus_xfer(input logic wr, input reg_addr_t a, input byte_t wd,
			output byte_t rd);
		int n;
		@(posedge clk_i);
		req <= '{sel: 1'b1, enable: 1'b0, write: wr, addr: a, wdata: wd};
		@(posedge clk_i);
		req.enable <= 1'b1;
		@(negedge clk_i);
		if (ready !== 1'b0)
			fail_plain("ready_o was not low in the cycle after the setup phase");
		n = 0;
		while (ready !== 1'b1 && n < 16) begin
			@(negedge clk_i);
			n++;
		end
		if (ready !== 1'b1)
			fail_plain("Timeout waiting for ready_o in the access phase");
		rd = rdata;
		@(posedge clk_i);
		req <= '0;
	endtask

	task automatic bus_write(input reg_addr_t a, input byte_t d);
		byte_t unused;
		bus_xfer(1'b1, a, d, unused);
	endtask

	task automatic bus_read(input reg_addr_t a, output byte_t d);
		bus_xfer(1'b0, a, '0, d);
	endtask

	task automatic wait_idle(output byte_t ctrl);
		int n;
		n = 0;
		bus_read(REG_CTRL, ctrl);
		while (ctrl[CTRL_BUSY] && n < 4000) begin
			bus_read(REG_CTRL, ctrl);
			n++;
		end
		if (ctrl[CTRL_BUSY])
			fail_plain("Timeout: the transaction never cleared busy");
	endtask

	task automatic check_frame(input byte_t exp[5], input int cnt);
		if (u_target.frame.size() != cnt)
			fail_value($sformatf("target saw %0d bytes, expected %0d",
				u_target.frame.size(), cnt));
		for (int i = 0; i < cnt; i++)
			check_byte(u_target.frame[i], exp[i], "bus byte");
		if (u_target.stops != 1)
			fail_value($sformatf("target saw %0d STOPs, expected 1", u_target.stops));
	endtask

	task automatic write_tdr(input word_t w);
		for (int i = 0; i < 4; i++)
			bus_write(REG_TDR0 + reg_addr_t'(i), w[8*i +: 8]);
	endtask

	initial begin
		byte_t rd;
		byte_t c;
		byte_t exp[5];
		int    cnt;
		word_t tdr;
		word_t got;

		req = '0;
		rst = 1'b1;
		served = '0;
		rdr_model = '0;
		tgt_addr = DEV;
		lcg_state = 32'h5c21_27d1;
		repeat (4) @(posedge clk_i);
		rst <= 1'b0;
		@(negedge clk_i);

		if (ready !== 1'b1 || scl !== 1'b1 || sda_o !== 1'b1)
			fail_plain("ready_o or the I2C pins were not high after reset");
		for (int a = 0; a <= int'(REG_CTRL); a++) begin
			bus_read(reg_addr_t'(a), rd);
			check_byte(rd, 8'h00, "register after reset");
		end

		// Register readback, masked to stored widths.
		lcg_state = lcg_step(lcg_state);
		bus_write(REG_NBY, lcg_state[7:0]);
		bus_read(REG_NBY, rd);
		check_byte(rd, {6'b0, lcg_state[1:0]}, "NBY readback");
		bus_write(REG_ADR, lcg_state[15:8]);
		bus_read(REG_ADR, rd);
		check_byte(rd, {1'b0, lcg_state[14:8]}, "ADR readback");
		lcg_state = lcg_step(lcg_state);
		tdr = lcg_state;
		write_tdr(tdr);
		for (int i = 0; i < 4; i++) begin
			bus_read(REG_TDR0 + reg_addr_t'(i), rd);
			got[8*i +: 8] = rd;
		end
		check_word(got, tdr, "TDR readback");
		for (int i = 0; i < 4; i++) begin
			bus_write(REG_RDR0 + reg_addr_t'(i), 8'hff);
			bus_read(REG_RDR0 + reg_addr_t'(i), rd);
			check_byte(rd, 8'h00, "RDR after write");
		end
		bus_write(8'h14, 8'h5a);
		bus_read(8'h14, rd);
		check_byte(rd, 8'h00, "unmapped offset");

		// Writes of 1 to 4 bytes.
		bus_write(REG_ADR, {1'b0, DEV});
		for (int n = 0; n < 4; n++) begin
			lcg_state = lcg_step(lcg_state);
			tdr = lcg_state;
			write_tdr(tdr);
			bus_write(REG_NBY, byte_t'(n));
			u_target.clear();
			bus_write(REG_CTRL, 8'h01);
			wait_idle(c);
			check_status(c, 1'b0, 1'b1, 1'b0);
			cnt = expect_frame(DEV, 1'b0, nby_t'(n), tdr, exp);
			check_frame(exp, cnt);
		end

		// Reads of 1 to 4 bytes.
		for (int n = 0; n < 4; n++) begin
			lcg_state = lcg_step(lcg_state);
			served = lcg_state;
			bus_write(REG_NBY, byte_t'(n));
			u_target.clear();
			bus_write(REG_CTRL, 8'h03);
			wait_idle(c);
			check_status(c, 1'b0, 1'b1, 1'b0);
			cnt = expect_frame(DEV, 1'b1, nby_t'(n), '0, exp);
			check_frame(exp, cnt);
			if (u_target.acks.size() != n + 1)
				fail_value($sformatf("target saw %0d master ACK bits, expected %0d",
					u_target.acks.size(), n + 1));
			for (int i = 0; i <= n; i++)
				check_byte({7'b0, u_target.acks[i]}, {7'b0, (i == n)}, "master ACK bit");
			for (int i = 0; i <= n; i++)
				rdr_model[8*i +: 8] = served[8*i +: 8];
			for (int i = 0; i < 4; i++) begin
				bus_read(REG_RDR0 + reg_addr_t'(i), rd);
				got[8*i +: 8] = rd;
			end
			check_word(got, rdr_model, "RDR after read");
		end

		// Address nobody owns.
		bus_write(REG_ADR, {1'b0, DEV ^ 7'h01});
		bus_write(REG_NBY, 8'h01);
		u_target.clear();
		bus_write(REG_CTRL, 8'h01);
		wait_idle(c);
		check_status(c, 1'b0, 1'b1, 1'b1);
		void'(expect_frame(DEV ^ 7'h01, 1'b0, 2'd1, tdr, exp));
		check_frame(exp, 1);

		// Second go during a transfer.
		bus_write(REG_ADR, {1'b0, DEV});
		bus_write(REG_NBY, 8'h03);
		u_target.clear();
		bus_write(REG_CTRL, 8'h01);
		bus_read(REG_CTRL, c);
		check_status(c, 1'b1, 1'b0, 1'b0);
		bus_write(REG_CTRL, 8'h01);
		wait_idle(c);
		check_status(c, 1'b0, 1'b1, 1'b0);
		cnt = expect_frame(DEV, 1'b0, 2'd3, tdr, exp);
		check_frame(exp, cnt);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
design/i2c_pkg.sv
design/i2c_regs.sv
design/i2c_scl_gen.sv
design/i2c_engine.sv
design/i2c_master.sv
sim/i2c_target_model.sv
sim/i2c_master_asserts.sv
sim/tb_i2c_master.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_i2c_master
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q ">>> FAIL" $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
